// ==== rtl/readout_config.svh ====
`ifndef READOUT_CONFIG_SVH
`define READOUT_CONFIG_SVH

// datapath shape
`define LANES       5       // lanes per stream word
`define SAMPLE_W    16
`define PHASE_W     6
`define PHASE_MOD   50      // phase wraps at 50
`define TABLE_ROWS  10
`define ROT_W       34      // rotated lane, full precision
`define TOTAL_W     48      // run total

// register fields
`define TRIG_W      14      // delay in clock cycles
`define LEN_W       11      // words per run
`define SKIP_W      6       // lane spacing

// word address map
`define ADDR_PHASE0 10      // rows 10..19
`define ADDR_LENGTH 20
`define ADDR_SKIP   21
`define ADDR_DELAY  22

// reset defaults
`define LEN_DEFAULT   2000
`define SKIP_DEFAULT  5
`define DELAY_DEFAULT 5000
`define ROW_EVEN_DEFAULT {6'd20, 6'd15, 6'd10, 6'd5, 6'd0}
`define ROW_ODD_DEFAULT  {6'd45, 6'd40, 6'd35, 6'd30, 6'd25}

`endif

// ==== rtl/readout_pkg.sv ====
`include "readout_config.svh"

package readout_pkg;

    ////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        DELAY,
        CAPTURE,
        FLUSH
    } seq_state_t;

    // decoded apb target
    typedef enum logic [2:0] {
        SEL_PHASE,
        SEL_LENGTH,
        SEL_SKIP,
        SEL_DELAY,
        SEL_NONE
    } reg_sel_t;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////

    typedef logic signed [`SAMPLE_W-1:0] lane_t;
    typedef lane_t [`LANES-1:0] lanes_t;            // lane 0 first in stream

    typedef logic [`PHASE_W-1:0] phase_t;           // 0..49
    typedef phase_t [`LANES-1:0] phase_row_t;
    typedef phase_row_t [`TABLE_ROWS-1:0] phase_table_t;

    typedef logic signed [`ROT_W-1:0] rot_t;
    typedef rot_t [`LANES-1:0] rot_lanes_t;

    typedef logic signed [`TOTAL_W-1:0] total_t;

endpackage

// ==== rtl/readout_regs.sv ====
`include "readout_config.svh"

module readout_regs (
    input  logic                       i_clk100,
    input  logic                       i_reset,
    input  logic                       i_psel,
    input  logic                       i_penable,
    input  logic                       i_pwrite,
    input  logic [7:0]                 i_paddr,
    input  logic [31:0]                i_pwdata,
    output logic [31:0]                o_prdata,
    output logic                       o_pready,
    output logic                       o_pslverr,
    output readout_pkg::phase_table_t  o_phase_table,
    output logic [`LEN_W-1:0]          o_length,
    output logic [`SKIP_W-1:0]         o_skip,
    output logic [`TRIG_W-1:0]         o_delay
);
    import readout_pkg::*;

    reg_sel_t   sel;
    logic [3:0] row_idx;
    logic       access;
    logic       refuse;

    assign row_idx = 4'(i_paddr - 8'(`ADDR_PHASE0));
    assign access  = i_psel & i_penable;
    assign o_pready = 1'b1;     // zero wait states

    always_comb begin
        if (i_paddr >= 8'(`ADDR_PHASE0) && i_paddr < 8'(`ADDR_PHASE0 + `TABLE_ROWS)) begin
            sel = SEL_PHASE;
        end else begin
            case (i_paddr)
                8'(`ADDR_LENGTH): sel = SEL_LENGTH;
                8'(`ADDR_SKIP):   sel = SEL_SKIP;
                8'(`ADDR_DELAY):  sel = SEL_DELAY;
                default:          sel = SEL_NONE;
            endcase
        end
    end

    // unmapped, or a zero lane spacing
    assign refuse = (sel == SEL_NONE) ||
                    (i_pwrite && sel == SEL_SKIP && i_pwdata[`SKIP_W-1:0] == '0);
    assign o_pslverr = access & refuse;

    always_comb begin
        case (sel)
            SEL_PHASE:  o_prdata = 32'(o_phase_table[row_idx]);
            SEL_LENGTH: o_prdata = 32'(o_length);
            SEL_SKIP:   o_prdata = 32'(o_skip);
            SEL_DELAY:  o_prdata = 32'(o_delay);
            default:    o_prdata = '0;
        endcase
    end

    always_ff @(posedge i_clk100) begin
        if (i_reset) begin
            for (int r = 0; r < `TABLE_ROWS; r++) begin
                o_phase_table[r] <= r[0] ? `ROW_ODD_DEFAULT : `ROW_EVEN_DEFAULT;
            end
            o_length <= `LEN_W'(`LEN_DEFAULT);
            o_skip   <= `SKIP_W'(`SKIP_DEFAULT);
            o_delay  <= `TRIG_W'(`DELAY_DEFAULT);
        end else if (access && i_pwrite && !refuse) begin
            case (sel)
                SEL_PHASE:  o_phase_table[row_idx] <= i_pwdata[$bits(phase_row_t)-1:0];
                SEL_LENGTH: o_length <= i_pwdata[`LEN_W-1:0];
                SEL_SKIP:   o_skip   <= i_pwdata[`SKIP_W-1:0];
                SEL_DELAY:  o_delay  <= i_pwdata[`TRIG_W-1:0];
                default:    ;
            endcase
        end
    end

    // phase_select would hang its offset walk on a zero spacing
    a_skip_nonzero: assert property (@(posedge i_clk100) disable iff (i_reset)
        o_skip != '0);

endmodule

// ==== rtl/run_sequencer.sv ====
`include "readout_config.svh"

module run_sequencer (
    input  logic              i_clk100,
    input  logic              i_reset,
    input  logic              i_trigger,
    input  logic [`TRIG_W-1:0] i_delay,
    input  logic [`LEN_W-1:0]  i_length,
    input  logic              i_done,
    output logic              o_busy,
    output logic              o_capture,
    output logic              o_first,
    output logic              o_last
);
    import readout_pkg::*;

    seq_state_t          state;
    logic [`TRIG_W-1:0]  dly_cnt;
    logic [`LEN_W-1:0]   word_cnt;

    assign o_busy    = (state != IDLE);
    assign o_capture = (state == CAPTURE);
    assign o_first   = o_capture && (word_cnt == '0);
    assign o_last    = o_capture && (word_cnt == i_length - 1'b1);

    always_ff @(posedge i_clk100) begin
        if (i_reset) begin
            state    <= IDLE;
            dly_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_trigger) begin    // triggers while busy never reach here
                        state   <= DELAY;
                        dly_cnt <= '0;
                    end
                end
                DELAY: begin
                    if (dly_cnt == i_delay - 1'b1) begin
                        state    <= CAPTURE;
                        word_cnt <= '0;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                CAPTURE: begin
                    if (o_last) begin
                        state <= FLUSH;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                FLUSH: begin
                    // done arrives one edge before the result register loads
                    if (i_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // pipeline drain must only report back while we wait for it
    a_done_in_flush: assert property (@(posedge i_clk100) disable iff (i_reset)
        i_done |-> state == FLUSH);

endmodule

// ==== rtl/phase_select.sv ====
`include "readout_config.svh"

module phase_select (
    input  logic                      i_clk100,
    input  logic                      i_reset,
    input  logic                      i_capture,
    input  logic                      i_first,
    input  logic                      i_last,
    input  logic [`SKIP_W-1:0]        i_skip,
    input  readout_pkg::phase_table_t i_phase_table,
    input  readout_pkg::lanes_t       i_data_i,
    input  readout_pkg::lanes_t       i_data_q,
    output logic                      o_valid,
    output logic                      o_first,
    output logic                      o_last,
    output logic [`LANES-1:0]         o_mask,
    output readout_pkg::phase_row_t   o_phase,
    output readout_pkg::lanes_t       o_data_i,
    output readout_pkg::lanes_t       o_data_q
);

    logic [`SKIP_W:0]   off_r;      // first selected lane of coming word, may lie past it
    logic [3:0]         row_r;
    logic [`SKIP_W:0]   cur_off;
    logic [`SKIP_W:0]   nxt;
    logic [3:0]         cur_row;
    logic [`LANES-1:0]  sel;

    // walk the selected positions across the word
    always_comb begin
        cur_off = i_first ? '0 : off_r;     // run starts on a selected lane
        cur_row = i_first ? '0 : row_r;
        nxt     = cur_off;
        for (int l = 0; l < `LANES; l++) begin
            sel[l] = (nxt == l);
            if (sel[l]) begin
                nxt = nxt + i_skip;
            end
        end
    end

    always_ff @(posedge i_clk100) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_first <= 1'b0;
            o_last  <= 1'b0;
            o_mask  <= '0;
            off_r   <= '0;
            row_r   <= '0;
        end else begin
            o_valid <= i_capture;
            o_first <= i_capture & i_first;
            o_last  <= i_capture & i_last;
            o_mask  <= i_capture ? sel : '0;
            if (i_capture) begin
                off_r <= nxt - (`SKIP_W+1)'(`LANES);    // rebase to next word
                row_r <= (cur_row == `TABLE_ROWS - 1) ? '0 : cur_row + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk100) begin
        o_data_i <= i_data_i;
        o_data_q <= i_data_q;
        for (int l = 0; l < `LANES; l++) begin
            o_phase[l] <= sel[l] ? i_phase_table[cur_row][l] : '0;
        end
    end

endmodule

// ==== rtl/iq_rotator.sv ====
`include "readout_config.svh"

module iq_rotator (
    input  logic                    i_clk100,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  logic                    i_first,
    input  logic                    i_last,
    input  logic [`LANES-1:0]       i_mask,
    input  readout_pkg::phase_row_t i_phase,
    input  readout_pkg::lanes_t     i_data_i,
    input  readout_pkg::lanes_t     i_data_q,
    output logic                    o_valid,
    output logic                    o_first,
    output logic                    o_last,
    output readout_pkg::rot_lanes_t o_rot_i,
    output readout_pkg::rot_lanes_t o_rot_q
);
    import readout_pkg::*;

    typedef lane_t trig_tab_t [`PHASE_MOD];

    localparam real PI  = 3.14159265358979;
    localparam real AMP = 16383.0;      // unit amplitude, Q1.14

    function automatic trig_tab_t build_tab(input bit use_sin);
        trig_tab_t tab;
        real       ang;
        for (int k = 0; k < `PHASE_MOD; k++) begin
            ang    = 2.0 * PI * k / `PHASE_MOD;
            tab[k] = lane_t'(int'(AMP * (use_sin ? $sin(ang) : $cos(ang))));
        end
        return tab;
    endfunction

    localparam trig_tab_t COS_TAB = build_tab(1'b0);
    localparam trig_tab_t SIN_TAB = build_tab(1'b1);

    lanes_t             cos_r;
    lanes_t             sin_r;
    lanes_t             d_i_r;
    lanes_t             d_q_r;
    logic [`LANES-1:0]  mask_r;
    logic               v_r;
    logic               f_r;
    logic               l_r;

    ////////////////////////////////////////
    // flags, two stages
    ////////////////////////////////////////

    always_ff @(posedge i_clk100) begin
        if (i_reset) begin
            v_r     <= 1'b0;
            f_r     <= 1'b0;
            l_r     <= 1'b0;
            o_valid <= 1'b0;
            o_first <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            v_r     <= i_valid;
            f_r     <= i_first;
            l_r     <= i_last;
            o_valid <= v_r;
            o_first <= f_r;
            o_last  <= l_r;
        end
    end

    always_ff @(posedge i_clk100) begin
        mask_r <= i_mask;
        d_i_r  <= i_data_i;
        d_q_r  <= i_data_q;
        for (int l = 0; l < `LANES; l++) begin
            cos_r[l] <= COS_TAB[i_phase[l]];
            sin_r[l] <= SIN_TAB[i_phase[l]];
        end
    end

    // stage two: complex rotation by -phase
    always_ff @(posedge i_clk100) begin
        for (int l = 0; l < `LANES; l++) begin
            if (mask_r[l]) begin
                o_rot_i[l] <= d_i_r[l] * cos_r[l] + d_q_r[l] * sin_r[l];
                o_rot_q[l] <= d_q_r[l] * cos_r[l] - d_i_r[l] * sin_r[l];
            end else begin
                o_rot_i[l] <= '0;       // unselected lane
                o_rot_q[l] <= '0;
            end
        end
    end

    for (genvar g = 0; g < `LANES; g++) begin : g_phase_chk
        a_phase_range: assert property (@(posedge i_clk100) disable iff (i_reset)
            i_valid |-> i_phase[g] < `PHASE_MOD);
    end

endmodule

// ==== rtl/iq_accumulator.sv ====
`include "readout_config.svh"

module iq_accumulator (
    input  logic                    i_clk100,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  logic                    i_first,
    input  logic                    i_last,
    input  readout_pkg::rot_lanes_t i_rot_i,
    input  readout_pkg::rot_lanes_t i_rot_q,
    output logic                    o_done,
    output logic                    o_valid,
    output readout_pkg::total_t     o_i_total,
    output readout_pkg::total_t     o_q_total
);
    import readout_pkg::*;

    total_t sum_i;
    total_t sum_q;
    total_t acc_i;
    total_t acc_q;

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int l = 0; l < `LANES; l++) begin
            sum_i = sum_i + i_rot_i[l];
            sum_q = sum_q + i_rot_q[l];
        end
    end

    // running total, restarted by the first word of a run
    always_ff @(posedge i_clk100) begin
        if (i_valid) begin
            acc_i <= i_first ? sum_i : acc_i + sum_i;
            acc_q <= i_first ? sum_q : acc_q + sum_q;
        end
    end

    always_ff @(posedge i_clk100) begin
        if (i_reset) begin
            o_done    <= 1'b0;
            o_valid   <= 1'b0;
            o_i_total <= '0;
            o_q_total <= '0;
        end else begin
            o_done  <= i_valid & i_last;    // last word now in acc
            o_valid <= o_done;
            if (o_done) begin
                o_i_total <= acc_i;         // held until the next run ends
                o_q_total <= acc_q;
            end
        end
    end

endmodule

// ==== rtl/readout_top.sv ====
`include "readout_config.svh"

module readout_top (
    input  logic                i_clk100,
    input  logic                i_reset,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  logic [7:0]          i_paddr,
    input  logic [31:0]         i_pwdata,
    output logic [31:0]         o_prdata,
    output logic                o_pready,
    output logic                o_pslverr,
    input  logic                i_trigger,
    input  readout_pkg::lanes_t i_data_i,
    input  readout_pkg::lanes_t i_data_q,
    output logic                o_busy,
    output logic                o_valid,
    output readout_pkg::total_t o_i_total,
    output readout_pkg::total_t o_q_total
);
    import readout_pkg::*;

    // configuration
    phase_table_t        phase_table;
    logic [`LEN_W-1:0]   length;
    logic [`SKIP_W-1:0]  skip;
    logic [`TRIG_W-1:0]  delay;

    // sequencer to selector
    logic                capture;
    logic                seq_first;
    logic                seq_last;
    logic                done;

    // selector to rotator
    logic                sel_valid;
    logic                sel_first;
    logic                sel_last;
    logic [`LANES-1:0]   sel_mask;
    phase_row_t          sel_phase;
    lanes_t              sel_data_i;
    lanes_t              sel_data_q;

    // rotator to accumulator
    logic                rot_valid;
    logic                rot_first;
    logic                rot_last;
    rot_lanes_t          rot_i;
    rot_lanes_t          rot_q;

    readout_regs u_regs (
        .i_clk100(i_clk100), .i_reset(i_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_phase_table(phase_table), .o_length(length), .o_skip(skip), .o_delay(delay)
    );

    run_sequencer u_seq (
        .i_clk100(i_clk100), .i_reset(i_reset), .i_trigger(i_trigger),
        .i_delay(delay), .i_length(length), .i_done(done),
        .o_busy(o_busy), .o_capture(capture), .o_first(seq_first), .o_last(seq_last)
    );

    phase_select u_sel (
        .i_clk100(i_clk100), .i_reset(i_reset),
        .i_capture(capture), .i_first(seq_first), .i_last(seq_last),
        .i_skip(skip), .i_phase_table(phase_table),
        .i_data_i(i_data_i), .i_data_q(i_data_q),
        .o_valid(sel_valid), .o_first(sel_first), .o_last(sel_last),
        .o_mask(sel_mask), .o_phase(sel_phase),
        .o_data_i(sel_data_i), .o_data_q(sel_data_q)
    );

    iq_rotator u_rot (
        .i_clk100(i_clk100), .i_reset(i_reset),
        .i_valid(sel_valid), .i_first(sel_first), .i_last(sel_last),
        .i_mask(sel_mask), .i_phase(sel_phase),
        .i_data_i(sel_data_i), .i_data_q(sel_data_q),
        .o_valid(rot_valid), .o_first(rot_first), .o_last(rot_last),
        .o_rot_i(rot_i), .o_rot_q(rot_q)
    );

    iq_accumulator u_acc (
        .i_clk100(i_clk100), .i_reset(i_reset),
        .i_valid(rot_valid), .i_first(rot_first), .i_last(rot_last),
        .i_rot_i(rot_i), .i_rot_q(rot_q),
        .o_done(done), .o_valid(o_valid), .o_i_total(o_i_total), .o_q_total(o_q_total)
    );

endmodule

// ==== dv/readout_tb.sv ====
`include "readout_config.svh"

module readout_tb;
    import readout_pkg::*;

    localparam int ROWS    = 8;
    localparam int MAX_LEN = 40;
    localparam real PI     = 3.14159265358979;

    // one run per entry: delay, length, skip, phase pattern, extra trigger
    int tab_delay [ROWS] = '{1, 4, 7, 1, 20, 2, 9, 3};
    int tab_len   [ROWS] = '{3, 12, 20, 40, 17, 33, 11, 25};
    int tab_skip  [ROWS] = '{1, 2, 3, 5, 7, 13, 5, 1};
    int tab_pat   [ROWS] = '{0, 1, 2, 0, 3, 1, 4, 2};
    int tab_extra [ROWS] = '{0, 0, 1, 0, 1, 0, 1, 0};

    logic        clk100;
    logic        reset;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [7:0]  i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        i_trigger;
    lanes_t      i_data_i;
    lanes_t      i_data_q;
    logic        o_busy;
    logic        o_valid;
    total_t      o_i_total;
    total_t      o_q_total;

    lane_t       word_i [MAX_LEN][`LANES];
    lane_t       word_q [MAX_LEN][`LANES];
    int          cos_tab [`PHASE_MOD];
    int          sin_tab [`PHASE_MOD];
    longint      exp_i;
    longint      exp_q;
    total_t      prev_i;
    total_t      prev_q;
    int          reg_errors;
    int          run_errors;
    int          cycles;
    int          limit;

    readout_top UUT (
        .i_clk100(clk100), .i_reset(reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_trigger(i_trigger), .i_data_i(i_data_i), .i_data_q(i_data_q),
        .o_busy(o_busy), .o_valid(o_valid), .o_i_total(o_i_total), .o_q_total(o_q_total)
    );

    always #5 clk100 = ~clk100;

    always @(posedge clk100) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: simulation ran past %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////

    function automatic int round_real(input real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(-x + 0.5);
    endfunction

    task automatic build_trig();
        real ang;
        for (int k = 0; k < `PHASE_MOD; k++) begin
            ang        = 2.0 * PI * k / 50.0;
            cos_tab[k] = round_real(16383.0 * $cos(ang));
            sin_tab[k] = round_real(16383.0 * $sin(ang));
        end
    endtask

    // pattern 0 is the reset table
    function automatic int phase_of(input int pat, input int row, input int lane);
        if (pat == 0) begin
            return (row % 2) * 25 + lane * 5;
        end
        return (pat * (7 * row + 3 * lane) + 11 * row) % 50;
    endfunction

    function automatic logic [31:0] row_word(input int pat, input int row);
        logic [31:0] v;
        v = '0;
        for (int l = 0; l < `LANES; l++) begin
            v[6*l +: 6] = 6'(phase_of(pat, row, l));
        end
        return v;
    endfunction

    task automatic compute_expected(input int pat, input int len, input int skip);
        int ph;
        exp_i = 0;
        exp_q = 0;
        for (int w = 0; w < len; w++) begin
            for (int l = 0; l < `LANES; l++) begin
                if ((5 * w + l) % skip == 0) begin     // stream index n = 5w + lane
                    ph    = phase_of(pat, w % 10, l);
                    exp_i += longint'(word_i[w][l]) * cos_tab[ph]
                           + longint'(word_q[w][l]) * sin_tab[ph];
                    exp_q += longint'(word_q[w][l]) * cos_tab[ph]
                           - longint'(word_i[w][l]) * sin_tab[ph];
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // bus and stream drivers
    ////////////////////////////////////////

    task automatic write_reg(input int addr, input logic [31:0] data, output logic err);
        i_psel    = 1'b1;
        i_pwrite  = 1'b1;
        i_paddr   = 8'(addr);
        i_pwdata  = data;
        i_penable = 1'b0;
        @(posedge clk100);
        #1;
        i_penable = 1'b1;
        @(negedge clk100);
        err = o_pslverr;
        @(posedge clk100);      // write lands here
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic read_reg(input int addr, output logic [31:0] data, output logic err);
        i_psel    = 1'b1;
        i_pwrite  = 1'b0;
        i_paddr   = 8'(addr);
        i_penable = 1'b0;
        @(posedge clk100);
        #1;
        i_penable = 1'b1;
        @(negedge clk100);
        data = o_prdata;
        err  = o_pslverr;
        if (o_pready !== 1'b1) begin
            $display("Error %0t: o_pready low in access phase", $time);
            reg_errors++;
        end
        @(posedge clk100);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic expect_reg(input int addr, input logic [31:0] want);
        logic [31:0] got;
        logic        err;
        read_reg(addr, got, err);
        if (err !== 1'b0 || got !== want) begin
            $display("Error %0t: address %0d read %0h (slverr %0b), expected %0h",
                     $time, addr, got, err, want);
            reg_errors++;
        end
    endtask

    task automatic write_ok(input int addr, input logic [31:0] data);
        logic err;
        write_reg(addr, data, err);
        if (err !== 1'b0) begin
            $display("Error %0t: write to address %0d refused", $time, addr);
            reg_errors++;
        end
    endtask

    // word w goes out for the next edge; anything outside the run is noise
    task automatic drive_lanes(input int w, input int len);
        for (int l = 0; l < `LANES; l++) begin
            if (w >= 0 && w < len) begin
                i_data_i[l] = word_i[w][l];
                i_data_q[l] = word_q[w][l];
            end else begin
                i_data_i[l] = lane_t'($urandom);
                i_data_q[l] = lane_t'($urandom);
            end
        end
    endtask

    ////////////////////////////////////////
    // test sections
    ////////////////////////////////////////

    task automatic check_reset_state();
        if (o_busy !== 1'b0 || o_valid !== 1'b0 || o_i_total !== '0 || o_q_total !== '0) begin
            $display("Error %0t: outputs not idle after reset", $time);
            reg_errors++;
        end
        for (int r = 0; r < 10; r++) begin
            expect_reg(`ADDR_PHASE0 + r, row_word(0, r));
        end
        expect_reg(`ADDR_LENGTH, 32'd2000);
        expect_reg(`ADDR_SKIP, 32'd5);
        expect_reg(`ADDR_DELAY, 32'd5000);
    endtask

    task automatic check_register_access();
        logic [31:0] data;
        logic        err;
        write_ok(`ADDR_LENGTH, 32'd123);
        expect_reg(`ADDR_LENGTH, 32'd123);
        write_ok(`ADDR_SKIP, 32'd9);
        expect_reg(`ADDR_SKIP, 32'd9);
        write_reg(`ADDR_SKIP, 32'd0, err);
        if (err !== 1'b1) begin
            $display("Error %0t: zero skip write gave no o_pslverr", $time);
            reg_errors++;
        end
        expect_reg(`ADDR_SKIP, 32'd9);     // value kept
        write_ok(`ADDR_DELAY, 32'd77);
        expect_reg(`ADDR_DELAY, 32'd77);
        write_ok(`ADDR_PHASE0 + 3, row_word(2, 3));
        expect_reg(`ADDR_PHASE0 + 3, row_word(2, 3));
        write_reg(5, 32'hdead, err);
        if (err !== 1'b1) begin
            $display("Error %0t: unmapped write gave no o_pslverr", $time);
            reg_errors++;
        end
        read_reg(30, data, err);
        if (err !== 1'b1 || data !== '0) begin
            $display("Error %0t: unmapped read gave %0h, slverr %0b", $time, data, err);
            reg_errors++;
        end
    endtask

    task automatic run_case(input int r);
        int   dly;
        int   len;
        int   n;
        logic seen;
        dly = tab_delay[r];
        len = tab_len[r];
        for (int row = 0; row < 10; row++) begin
            write_ok(`ADDR_PHASE0 + row, row_word(tab_pat[r], row));
        end
        write_ok(`ADDR_LENGTH, len);
        write_ok(`ADDR_SKIP, tab_skip[r]);
        write_ok(`ADDR_DELAY, dly);
        for (int w = 0; w < len; w++) begin
            for (int l = 0; l < `LANES; l++) begin
                word_i[w][l] = lane_t'($urandom);
                word_q[w][l] = lane_t'($urandom);
            end
        end
        compute_expected(tab_pat[r], len, tab_skip[r]);

        i_trigger = 1'b1;
        @(posedge clk100);      // trigger edge, n counts from here
        #1;
        i_trigger = 1'b0;
        n = 0;
        seen = 1'b0;
        if (o_busy !== 1'b1) begin
            $display("Error %0t: run %0d o_busy did not rise", $time, r);
            run_errors++;
        end
        drive_lanes(n - dly, len);
        while (!seen && n < dly + len + 20) begin
            @(posedge clk100);
            #1;
            n++;
            if (o_valid === 1'b1) begin
                seen = 1'b1;
            end else if (o_busy !== 1'b1 || o_i_total !== prev_i || o_q_total !== prev_q) begin
                $display("Error %0t: run %0d busy low or totals moved at cycle %0d",
                         $time, r, n);
                run_errors++;
            end
            i_trigger = (tab_extra[r] != 0) && (n == dly + len / 2);   // ignored while busy
            drive_lanes(n - dly, len);
        end
        i_trigger = 1'b0;

        if (!seen) begin
            $display("Run %0d: o_valid never came within %0d cycles of the trigger", r, n);
            run_errors++;
        end else begin
            if (n != dly + len + 4 || o_busy !== 1'b0) begin
                $display("Error %0t: run %0d valid at cycle %0d busy %0b, expected cycle %0d",
                         $time, r, n, o_busy, dly + len + 4);
                run_errors++;
            end
            if (o_i_total !== 48'(exp_i) || o_q_total !== 48'(exp_q)) begin
                $display("Error %0t: run %0d totals %0d/%0d, expected %0d/%0d",
                         $time, r, o_i_total, o_q_total, exp_i, exp_q);
                run_errors++;
            end
            @(posedge clk100);
            #1;
            drive_lanes(-1, 0);
            if (o_valid !== 1'b0 || o_busy !== 1'b0) begin
                $display("Error %0t: run %0d valid wider than one cycle or busy again",
                         $time, r);
                run_errors++;
            end
        end
        prev_i = 48'(exp_i);
        prev_q = 48'(exp_q);
    endtask

    initial begin
        void'($urandom(32'h1cdd));
        clk100     = 1'b0;
        reset      = 1'b1;
        i_psel     = 1'b0;
        i_penable  = 1'b0;
        i_pwrite   = 1'b0;
        i_paddr    = '0;
        i_pwdata   = '0;
        i_trigger  = 1'b0;
        i_data_i   = '0;
        i_data_q   = '0;
        prev_i     = '0;
        prev_q     = '0;
        reg_errors = 0;
        run_errors = 0;
        cycles     = 0;
        limit      = 0;
        for (int r = 0; r < ROWS; r++) begin
            limit += 2 * (tab_delay[r] + tab_len[r] + 30);
        end
        build_trig();

        repeat (8) @(posedge clk100);
        #1;
        reset = 1'b0;

        check_reset_state();
        check_register_access();
        for (int r = 0; r < ROWS; r++) begin
            run_case(r);
        end

        $display("Register errors: %0d, run errors: %0d, runs: %0d",
                 reg_errors, run_errors, ROWS);
        if (reg_errors + run_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/readout_pkg.sv
rtl/readout_regs.sv
rtl/run_sequencer.sv
rtl/phase_select.sv
rtl/iq_rotator.sv
rtl/iq_accumulator.sv
rtl/readout_top.sv
dv/readout_tb.sv
